// File: hdl/w0rm_lite_pkg.sv
`default_nettype none

package w0rm_lite_pkg;

  // ------------------------------------------------------------
  // widths
  // ------------------------------------------------------------
  localparam int data_width    = 32;
  localparam int inst_width    = 16;
  localparam int reg_count     = 16;
  localparam int reg_idx_width = 4;
  localparam int op_width      = 4;
  localparam int imm_width     = 8;
  localparam int state_width   = 3;

  localparam logic [data_width-1:0] pc_step = 32'd2; // halfword instructions.

  // ------------------------------------------------------------
  // opcodes, unlisted codes fall through as no-ops
  // ------------------------------------------------------------
  localparam logic [op_width-1:0] op_add  = 4'd0;
  localparam logic [op_width-1:0] op_sub  = 4'd1;
  localparam logic [op_width-1:0] op_and  = 4'd2;
  localparam logic [op_width-1:0] op_or   = 4'd3;
  localparam logic [op_width-1:0] op_xor  = 4'd4;
  localparam logic [op_width-1:0] op_ldi  = 4'd5;
  localparam logic [op_width-1:0] op_shl  = 4'd6;
  localparam logic [op_width-1:0] op_ld   = 4'd7;
  localparam logic [op_width-1:0] op_st   = 4'd8;
  localparam logic [op_width-1:0] op_bnz  = 4'd9;
  localparam logic [op_width-1:0] op_halt = 4'd15;

  // control states.
  localparam logic [state_width-1:0] st_fetch     = 3'd0;
  localparam logic [state_width-1:0] st_wait_inst = 3'd1;
  localparam logic [state_width-1:0] st_execute   = 3'd2;
  localparam logic [state_width-1:0] st_mem_issue = 3'd3;
  localparam logic [state_width-1:0] st_mem_wait  = 3'd4;
  localparam logic [state_width-1:0] st_halt      = 3'd5;

  // one instruction word, register view and immediate view.
  typedef union packed {
    struct packed {
      logic [op_width-1:0]      opcode;
      logic [reg_idx_width-1:0] rd;
      logic [reg_idx_width-1:0] rs;
      logic [reg_idx_width-1:0] rt;
    } r;
    struct packed {
      logic [op_width-1:0]      opcode;
      logic [reg_idx_width-1:0] rd;
      logic [imm_width-1:0]     imm8;
    } i;
  } w0rm_inst_u;

endpackage

`default_nettype wire

// File: hdl/w0rm_lite_control.sv
`timescale 1ns/1ps
`default_nettype none

module w0rm_lite_control
  import w0rm_lite_pkg::*;
(
  input  logic                clk,
  input  logic                rst_i,
  input  logic                inst_valid_i,
  input  logic                mem_valid_i,
  input  logic [op_width-1:0] opcode_i,
  input  logic                rd_nonzero_i,
  output logic                inst_valid_o,
  output logic                ir_load_o,
  output logic                reg_write_o,
  output logic                load_write_o,
  output logic                pc_advance_o,
  output logic                pc_branch_o,
  output logic                mem_start_o,
  output logic                mem_read_o,
  output logic                mem_write_o,
  output logic                halted_o
);

  logic [state_width-1:0] state_q;
  logic [state_width-1:0] state_d;
  logic                   is_mem_op;
  logic                   writes_reg;
  logic                   in_execute;

  assign is_mem_op  = (opcode_i == op_ld) || (opcode_i == op_st);
  assign writes_reg = opcode_i inside {op_add, op_sub, op_and, op_or, op_xor, op_ldi, op_shl};
  assign in_execute = (state_q == st_execute);

  // ------------------------------------------------------------
  // next state
  // ------------------------------------------------------------
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      st_fetch:     state_d = st_wait_inst;
      st_wait_inst:
        if (inst_valid_i)
          state_d = st_execute;
      st_execute:
        if (is_mem_op)
          state_d = st_mem_issue;
        else if (opcode_i == op_halt)
          state_d = st_halt;
        else
          state_d = st_wait_inst; // next request goes out right away.
      st_mem_issue: state_d = st_mem_wait;
      st_mem_wait:
        if (mem_valid_i)
          state_d = st_wait_inst;
      st_halt:      state_d = st_halt; // parked until reset.
      default:      state_d = st_fetch;
    endcase
  end

  // request strobes are registered, high for the first cycle of the target state.
  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      state_q      <= st_fetch;
      inst_valid_o <= 1'b0;
      mem_start_o  <= 1'b0;
      mem_read_o   <= 1'b0;
      mem_write_o  <= 1'b0;
    end
    else
    begin
      state_q      <= state_d;
      inst_valid_o <= (state_d == st_wait_inst) && (state_q != st_wait_inst);
      mem_start_o  <= (state_d == st_mem_issue);
      mem_read_o   <= (state_d == st_mem_issue) && (opcode_i == op_ld);
      mem_write_o  <= (state_d == st_mem_issue) && (opcode_i == op_st);
    end
  end

  // ------------------------------------------------------------
  // datapath controls
  // ------------------------------------------------------------
  assign ir_load_o    = (state_q == st_wait_inst) && inst_valid_i;
  assign load_write_o = (state_q == st_mem_wait) && (opcode_i == op_ld);
  assign reg_write_o  = (in_execute && writes_reg) || (load_write_o && mem_valid_i);
  assign pc_branch_o  = in_execute && (opcode_i == op_bnz) && rd_nonzero_i; // taken branch.
  assign pc_advance_o = in_execute && (opcode_i != op_halt) && !pc_branch_o;
  assign halted_o     = (state_q == st_halt);

endmodule

`default_nettype wire

// File: hdl/w0rm_lite_pc.sv
`timescale 1ns/1ps
`default_nettype none

module w0rm_lite_pc
  import w0rm_lite_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_i,
  input  logic                  pc_advance_i,
  input  logic                  pc_branch_i,
  input  logic [imm_width-1:0]  imm8_i,
  output logic [data_width-1:0] pc_o
);

  logic [data_width-1:0] pc_q;
  logic [data_width-1:0] offset;

  // sign-extended imm8 in halfwords.
  assign offset = {{(data_width-imm_width-1){imm8_i[imm_width-1]}}, imm8_i, 1'b0};

  always_ff @(posedge clk)
  begin
    if (rst_i)
      pc_q <= '0;
    else if (pc_branch_i)
      pc_q <= pc_q + pc_step + offset; // relative to the next instruction.
    else if (pc_advance_i)
      pc_q <= pc_q + pc_step;
  end

  assign pc_o = pc_q;

endmodule

`default_nettype wire

// File: hdl/w0rm_lite_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module w0rm_lite_regfile
  import w0rm_lite_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_i,
  input  logic                     we_i,
  input  logic [reg_idx_width-1:0] waddr_i,
  input  logic [data_width-1:0]    wdata_i,
  input  logic [reg_idx_width-1:0] raddr_a_i,
  input  logic [reg_idx_width-1:0] raddr_b_i,
  input  logic [reg_idx_width-1:0] raddr_d_i,
  output logic [data_width-1:0]    rdata_a_o,
  output logic [data_width-1:0]    rdata_b_o,
  output logic [data_width-1:0]    rdata_d_o
);

  logic [data_width-1:0] regs_q [reg_count];

  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      for (int i = 0; i < reg_count; i++)
        regs_q[i] <= '0;
    end
    else if (we_i)
      regs_q[waddr_i] <= wdata_i;
  end

  // asynchronous reads, no bypass needed in a multi-cycle core.
  assign rdata_a_o = regs_q[raddr_a_i];
  assign rdata_b_o = regs_q[raddr_b_i];
  assign rdata_d_o = regs_q[raddr_d_i];

endmodule

`default_nettype wire

// File: hdl/w0rm_lite_execute.sv
`timescale 1ns/1ps
`default_nettype none

module w0rm_lite_execute
  import w0rm_lite_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_i,
  input  logic                     ir_load_i,
  input  logic [inst_width-1:0]    inst_data_i,
  input  logic                     load_write_i,
  input  logic                     mem_valid_i,
  input  logic [data_width-1:0]    mem_data_i,
  input  logic [data_width-1:0]    rdata_a_i,
  input  logic [data_width-1:0]    rdata_b_i,
  input  logic [data_width-1:0]    rdata_d_i,
  output logic [op_width-1:0]      opcode_o,
  output logic [imm_width-1:0]     imm8_o,
  output logic [reg_idx_width-1:0] rs_o,
  output logic [reg_idx_width-1:0] rt_o,
  output logic [reg_idx_width-1:0] rd_o,
  output logic                     rd_nonzero_o,
  output logic [data_width-1:0]    wdata_o,
  output logic [data_width-1:0]    mem_addr_o,
  output logic [data_width-1:0]    mem_data_o
);

  w0rm_inst_u            ir_q;
  logic [data_width-1:0] alu_result;

  always_ff @(posedge clk)
  begin
    if (ir_load_i)
      ir_q <= inst_data_i;
  end

  // ------------------------------------------------------------
  // decode, both views of the same word
  // ------------------------------------------------------------
  assign opcode_o     = ir_q.r.opcode;
  assign rd_o         = ir_q.r.rd;
  assign rs_o         = ir_q.r.rs;
  assign rt_o         = ir_q.r.rt;
  assign imm8_o       = ir_q.i.imm8;
  assign rd_nonzero_o = |rdata_d_i; // branch condition.

  always_comb
  begin
    case (opcode_o)
      op_add:  alu_result = rdata_a_i + rdata_b_i;
      op_sub:  alu_result = rdata_a_i - rdata_b_i;
      op_and:  alu_result = rdata_a_i & rdata_b_i;
      op_or:   alu_result = rdata_a_i | rdata_b_i;
      op_xor:  alu_result = rdata_a_i ^ rdata_b_i;
      op_shl:  alu_result = rdata_a_i << rdata_b_i[4:0]; // amount masked to 5 bits.
      op_ldi:  alu_result = {{(data_width-imm_width){1'b0}}, ir_q.i.imm8};
      default: alu_result = '0;
    endcase
  end

  // load data is taken straight off the response strobe.
  assign wdata_o = (load_write_i && mem_valid_i) ? mem_data_i : alu_result;

  // data port address and store data, rs and rd.
  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      mem_addr_o <= '0;
      mem_data_o <= '0;
    end
    else
    begin
      mem_addr_o <= rdata_a_i;
      mem_data_o <= rdata_d_i;
    end
  end

endmodule

`default_nettype wire

// File: hdl/w0rm_lite_top.sv
`timescale 1ns/1ps
`default_nettype none

module w0rm_lite_top
  import w0rm_lite_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_i,
  // ------------------------------------------------------------
  // instruction port
  // ------------------------------------------------------------
  output logic [data_width-1:0] inst_addr_o,
  output logic                  inst_valid_o,
  input  logic [inst_width-1:0] inst_data_i,
  input  logic                  inst_valid_i,
  // ------------------------------------------------------------
  // data port
  // ------------------------------------------------------------
  output logic [data_width-1:0] mem_addr_o,
  output logic [data_width-1:0] mem_data_o,
  output logic                  mem_read_o,
  output logic                  mem_write_o,
  output logic                  mem_valid_o,
  input  logic [data_width-1:0] mem_data_i,
  input  logic                  mem_valid_i,
  output logic                  halted_o
);

  logic [op_width-1:0]      opcode;
  logic                     rd_nonzero;
  logic                     ir_load;
  logic                     reg_write;
  logic                     load_write;
  logic                     pc_advance;
  logic                     pc_branch;
  logic [imm_width-1:0]     imm8;
  logic [reg_idx_width-1:0] rs;
  logic [reg_idx_width-1:0] rt;
  logic [reg_idx_width-1:0] rd;
  logic [data_width-1:0]    wdata;
  logic [data_width-1:0]    rdata_a;
  logic [data_width-1:0]    rdata_b;
  logic [data_width-1:0]    rdata_d;

  w0rm_lite_control u_control (
    .clk          (clk),
    .rst_i        (rst_i),
    .inst_valid_i (inst_valid_i),
    .mem_valid_i  (mem_valid_i),
    .opcode_i     (opcode),
    .rd_nonzero_i (rd_nonzero),
    .inst_valid_o (inst_valid_o),
    .ir_load_o    (ir_load),
    .reg_write_o  (reg_write),
    .load_write_o (load_write),
    .pc_advance_o (pc_advance),
    .pc_branch_o  (pc_branch),
    .mem_start_o  (mem_valid_o),
    .mem_read_o   (mem_read_o),
    .mem_write_o  (mem_write_o),
    .halted_o     (halted_o)
  );

  w0rm_lite_pc u_pc (
    .clk          (clk),
    .rst_i        (rst_i),
    .pc_advance_i (pc_advance),
    .pc_branch_i  (pc_branch),
    .imm8_i       (imm8),
    .pc_o         (inst_addr_o) // fetch address.
  );

  w0rm_lite_regfile u_regfile (
    .clk       (clk),
    .rst_i     (rst_i),
    .we_i      (reg_write),
    .waddr_i   (rd),
    .wdata_i   (wdata),
    .raddr_a_i (rs),
    .raddr_b_i (rt),
    .raddr_d_i (rd),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .rdata_d_o (rdata_d)
  );

  w0rm_lite_execute u_execute (
    .clk          (clk),
    .rst_i        (rst_i),
    .ir_load_i    (ir_load),
    .inst_data_i  (inst_data_i),
    .load_write_i (load_write),
    .mem_valid_i  (mem_valid_i),
    .mem_data_i   (mem_data_i),
    .rdata_a_i    (rdata_a),
    .rdata_b_i    (rdata_b),
    .rdata_d_i    (rdata_d),
    .opcode_o     (opcode),
    .imm8_o       (imm8),
    .rs_o         (rs),
    .rt_o         (rt),
    .rd_o         (rd),
    .rd_nonzero_o (rd_nonzero),
    .wdata_o      (wdata),
    .mem_addr_o   (mem_addr_o),
    .mem_data_o   (mem_data_o)
  );

endmodule

`default_nettype wire

// File: sim/w0rm_lite_checker.sv
`timescale 1ns/1ps
`default_nettype none

module w0rm_lite_checker (
  input  logic clk,
  input  logic rst_i,
  input  logic inst_req_i,
  input  logic inst_resp_i,
  input  logic mem_req_i,
  input  logic mem_resp_i,
  input  logic mem_read_i,
  input  logic mem_write_i,
  input  logic halted_i
);

  int   fail_count = 0;
  logic inst_busy_q;
  logic mem_busy_q;

  // one request in flight per port until its response.
  always @(posedge clk)
  begin
    if (rst_i)
    begin
      inst_busy_q <= 1'b0;
      mem_busy_q  <= 1'b0;
    end
    else
    begin
      if (inst_req_i)
        inst_busy_q <= 1'b1;
      else if (inst_resp_i)
        inst_busy_q <= 1'b0;
      if (mem_req_i)
        mem_busy_q <= 1'b1;
      else if (mem_resp_i)
        mem_busy_q <= 1'b0;
    end
  end

  // ------------------------------------------------------------
  // port protocol
  // ------------------------------------------------------------
  inst_pulse: assert property (@(posedge clk) disable iff (rst_i) inst_req_i |=> !inst_req_i)
    else
    begin
      $error("instruction request wider than one cycle");
      fail_count = fail_count + 1;
    end

  mem_pulse: assert property (@(posedge clk) disable iff (rst_i) mem_req_i |=> !mem_req_i)
    else
    begin
      $error("data request wider than one cycle");
      fail_count = fail_count + 1;
    end

  rw_exclusive: assert property (@(posedge clk) disable iff (rst_i) !(mem_read_i && mem_write_i))
    else
    begin
      $error("read and write high together");
      fail_count = fail_count + 1;
    end

  rw_with_req: assert property (@(posedge clk) disable iff (rst_i)
    (mem_read_i || mem_write_i) |-> mem_req_i)
    else
    begin
      $error("read or write without data request");
      fail_count = fail_count + 1;
    end

  one_outstanding: assert property (@(posedge clk) disable iff (rst_i)
    (inst_req_i || mem_req_i) |-> !(inst_busy_q || mem_busy_q))
    else
    begin
      $error("request issued while another is outstanding");
      fail_count = fail_count + 1;
    end

  quiet_halt: assert property (@(posedge clk) disable iff (rst_i)
    halted_i |-> !(inst_req_i || mem_req_i))
    else
    begin
      $error("request issued after halt");
      fail_count = fail_count + 1;
    end

endmodule

bind w0rm_lite_top w0rm_lite_checker u_checker (
  .clk         (clk),
  .rst_i       (rst_i),
  .inst_req_i  (inst_valid_o),
  .inst_resp_i (inst_valid_i),
  .mem_req_i   (mem_valid_o),
  .mem_resp_i  (mem_valid_i),
  .mem_read_i  (mem_read_o),
  .mem_write_i (mem_write_o),
  .halted_i    (halted_o)
);

`default_nettype wire

// File: sim/w0rm_lite_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module w0rm_lite_monitor
  import w0rm_lite_pkg::*;
(
  input  logic        clk,
  input  logic        rst_i,
  input  logic        inst_req_i,
  input  logic [31:0] inst_addr_i,
  input  logic        mem_req_i,
  input  logic        mem_read_i,
  input  logic        mem_write_i,
  input  logic [31:0] mem_addr_i,
  input  logic [31:0] mem_wdata_i,
  input  logic        mem_resp_i,
  input  logic [31:0] mem_rdata_i,
  input  logic        halted_i,
  output logic        model_ready_o,
  output int          model_insts_o,
  output int          errors_o,
  output logic        done_o
);

  localparam int step_limit = 1000; // runaway guard for the model.

  logic [31:0] model_mem [1024];
  logic [31:0] model_regs [reg_count];
  bit          exp_write [$];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];

  logic model_ready  = 1'b0;
  logic done         = 1'b0;
  logic halt_seen    = 1'b0;
  logic read_pending = 1'b0;
  int   model_insts  = 0;
  int   errors       = 0;
  int   rst_cycles   = 0;
  int   fetches      = 0;
  int   txn_idx      = 0;
  int   read_idx     = 0;
  int   quiet_cycles = 0;

  assign model_ready_o = model_ready;
  assign model_insts_o = model_insts;
  assign errors_o      = errors;
  assign done_o        = done;

  task automatic compare_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("FAILED %s expected %08h actual %08h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic report_problem(input string what);
    $display("ERROR: %s", what);
    errors++;
  endtask

  // ------------------------------------------------------------
  // reference model that runs the program image to its halt
  // ------------------------------------------------------------
  function automatic int run_model();
    w0rm_inst_u  inst;
    logic [31:0] pc;
    logic [31:0] next_pc;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] d;
    int          offset;
    int          count;
    bit          stop;
    pc    = 32'd0;
    count = 0;
    stop  = 1'b0;
    exp_write.delete();
    exp_addr.delete();
    exp_data.delete();
    for (int r = 0; r < reg_count; r++)
      model_regs[r] = 32'd0;
    for (int w = 0; w < 1024; w++)
      model_mem[w] = w0rm_lite_tb.init_mem[w];
    while (!stop && count < step_limit)
    begin
      inst    = w0rm_lite_tb.prog_mem[pc[6:1]];
      a       = model_regs[inst.r.rs];
      b       = model_regs[inst.r.rt];
      d       = model_regs[inst.r.rd];
      offset  = int'($signed(inst.i.imm8));
      next_pc = pc + 32'd2;
      count++;
      case (inst.r.opcode)
        op_add: model_regs[inst.r.rd] = a + b;
        op_sub: model_regs[inst.r.rd] = a - b;
        op_and: model_regs[inst.r.rd] = a & b;
        op_or:  model_regs[inst.r.rd] = a | b;
        op_xor: model_regs[inst.r.rd] = a ^ b;
        op_shl: model_regs[inst.r.rd] = a << b[4:0];
        op_ldi: model_regs[inst.r.rd] = {24'd0, inst.i.imm8};
        op_ld:
        begin
          exp_write.push_back(1'b0);
          exp_addr.push_back(a);
          exp_data.push_back(model_mem[a[11:2]]);
          model_regs[inst.r.rd] = model_mem[a[11:2]];
        end
        op_st:
        begin
          exp_write.push_back(1'b1);
          exp_addr.push_back(a);
          exp_data.push_back(d);
          model_mem[a[11:2]] = d;
        end
        op_bnz:
          if (d != 32'd0)
            next_pc = pc + 32'd2 + 2 * offset; // offset counts instructions.
        op_halt: stop = 1'b1;
        default: ; // unused codes do nothing.
      endcase
      pc = next_pc;
    end
    return count;
  endfunction

  // ------------------------------------------------------------
  // compare process
  // ------------------------------------------------------------
  always @(posedge clk)
  begin
    if (rst_i)
    begin
      rst_cycles++;
      if (rst_cycles > 2 && (inst_req_i || mem_req_i || mem_read_i || mem_write_i || halted_i))
        report_problem("a strobe or the halt flag is active during reset");
    end
    else
    begin
      if (!model_ready)
      begin
        model_insts = run_model();
        model_ready = 1'b1;
      end
      if (inst_req_i)
      begin
        if (fetches == 0)
          compare_word("first fetch address", 32'd0, inst_addr_i);
        fetches++;
      end
      if (mem_resp_i && read_pending)
      begin
        compare_word($sformatf("load %0d data", read_idx), exp_data[read_idx], mem_rdata_i);
        read_pending = 1'b0;
      end
      if (mem_req_i)
      begin
        if (txn_idx >= exp_addr.size())
          report_problem("data transaction issued beyond the expected list");
        else
        begin
          compare_word($sformatf("txn %0d kind", txn_idx),
                       exp_write[txn_idx] ? 32'd2 : 32'd1, {30'd0, mem_write_i, mem_read_i});
          compare_word($sformatf("txn %0d addr", txn_idx), exp_addr[txn_idx], mem_addr_i);
          if (exp_write[txn_idx])
            compare_word($sformatf("txn %0d data", txn_idx), exp_data[txn_idx], mem_wdata_i);
          else
          begin
            read_pending = 1'b1;
            read_idx     = txn_idx;
          end
          txn_idx++;
        end
      end
      if (halted_i && !halt_seen)
      begin
        halt_seen = 1'b1;
        compare_word("transaction count", exp_addr.size(), txn_idx);
        compare_word("instruction count", model_insts, fetches);
      end
      if (halt_seen)
      begin
        if (inst_req_i)
          report_problem("instruction fetch issued after halt");
        quiet_cycles++; // stray requests after halt show up here.
        if (quiet_cycles == 20)
          done = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: sim/w0rm_lite_tb.sv
`timescale 1ns/1ps
`default_nettype none

module w0rm_lite_tb
  import w0rm_lite_pkg::*;
;

  localparam logic [31:0] seed = 32'hfeed6cc7;

  logic        clk         = 1'b0;
  logic        rst_i       = 1'b1;
  logic [15:0] inst_data   = 16'd0;
  logic        inst_resp   = 1'b0;
  logic [31:0] mem_rdata   = 32'd0;
  logic        mem_resp    = 1'b0;
  logic [31:0] inst_addr;
  logic        inst_req;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic        mem_read;
  logic        mem_write;
  logic        mem_req;
  logic        halted;

  logic [15:0] prog_mem [64];
  logic [31:0] init_mem [1024];
  logic [31:0] data_mem [1024];
  int          prog_len = 0;
  logic [31:0] lat_rng;
  logic [31:0] fetch_addr;
  logic        inst_busy;
  int          inst_wait;
  logic        model_ready;
  int          model_insts;
  int          check_errors;
  logic        check_done;
  int          total_errors;

  always #2 clk = ~clk; // 4 ns period.

  w0rm_lite_top DUT (
    .clk          (clk),
    .rst_i        (rst_i),
    .inst_addr_o  (inst_addr),
    .inst_valid_o (inst_req),
    .inst_data_i  (inst_data),
    .inst_valid_i (inst_resp),
    .mem_addr_o   (mem_addr),
    .mem_data_o   (mem_wdata),
    .mem_read_o   (mem_read),
    .mem_write_o  (mem_write),
    .mem_valid_o  (mem_req),
    .mem_data_i   (mem_rdata),
    .mem_valid_i  (mem_resp),
    .halted_o     (halted)
  );

  w0rm_lite_monitor u_monitor (
    .clk           (clk),
    .rst_i         (rst_i),
    .inst_req_i    (inst_req),
    .inst_addr_i   (inst_addr),
    .mem_req_i     (mem_req),
    .mem_read_i    (mem_read),
    .mem_write_i   (mem_write),
    .mem_addr_i    (mem_addr),
    .mem_wdata_i   (mem_wdata),
    .mem_resp_i    (mem_resp),
    .mem_rdata_i   (mem_rdata),
    .halted_i      (halted),
    .model_ready_o (model_ready),
    .model_insts_o (model_insts),
    .errors_o      (check_errors),
    .done_o        (check_done)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [15:0] r_form(input logic [3:0] op, input int rd, input int rs,
                                         input int rt);
    return {op, rd[3:0], rs[3:0], rt[3:0]};
  endfunction

  function automatic logic [15:0] i_form(input logic [3:0] op, input int rd,
                                         input logic [7:0] imm);
    return {op, rd[3:0], imm};
  endfunction

  task automatic emit(input logic [15:0] word);
    prog_mem[prog_len] = word;
    prog_len++;
  endtask

  // store at the pointer in r14, then bump it by r13.
  task automatic store_next(input int rd);
    emit(r_form(op_st, rd, 14, 0));
    emit(r_form(op_add, 14, 14, 13));
  endtask

  // ------------------------------------------------------------
  // program and data images
  // ------------------------------------------------------------
  task automatic load_images();
    logic [31:0] state;
    state = seed;
    for (int w = 0; w < 1024; w++)
    begin
      state       = xorshift(state);
      init_mem[w] = state;
    end
    for (int p = 0; p < 64; p++)
      prog_mem[p] = i_form(op_halt, 0, 8'h00); // runaway fetches stop.
    emit(i_form(op_ldi, 1, 8'ha7));
    emit(i_form(op_ldi, 2, 8'h35));
    emit(i_form(op_ldi, 13, 8'h04));
    emit(i_form(op_ldi, 14, 8'h80)); // results from word 32 up.
    emit(i_form(op_ldi, 6, 8'd20));
    emit(r_form(op_shl, 1, 1, 6));
    emit(r_form(op_or, 1, 1, 2));
    emit(r_form(op_add, 4, 1, 2));
    store_next(4);
    emit(r_form(op_sub, 4, 2, 1));
    store_next(4);
    emit(r_form(op_and, 4, 1, 2));
    store_next(4);
    emit(r_form(op_xor, 4, 1, 2));
    store_next(4);
    emit(i_form(op_ldi, 7, 8'h23)); // 35, masked to 3.
    emit(r_form(op_shl, 4, 1, 7));
    store_next(4);
    emit(16'ha000); // unused opcode.
    emit(i_form(op_ldi, 9, 8'h10));
    emit(r_form(op_ld, 10, 9, 0));
    store_next(10);
    emit(i_form(op_ldi, 9, 8'h44));
    emit(r_form(op_ld, 10, 9, 0));
    emit(r_form(op_xor, 10, 10, 1));
    store_next(10);
    emit(r_form(op_sub, 12, 14, 13)); // read back the last store.
    emit(r_form(op_ld, 11, 12, 0));
    emit(r_form(op_add, 11, 11, 2));
    store_next(11);
    // count-down loop, three passes.
    emit(i_form(op_ldi, 5, 8'd3));
    emit(i_form(op_ldi, 15, 8'd1));
    store_next(5);
    emit(r_form(op_sub, 5, 5, 15));
    emit(i_form(op_bnz, 5, 8'hfc)); // back to the store.
    store_next(5);
    emit(i_form(op_halt, 0, 8'h00));
    emit(i_form(op_ldi, 1, 8'hee)); // never reached.
    store_next(1);
  endtask

  // instruction memory, 1 to 3 cycles of latency.
  always @(posedge clk)
  begin
    inst_resp <= 1'b0;
    if (rst_i)
    begin
      lat_rng   = seed;
      inst_busy = 1'b0;
    end
    else
    begin
      if (inst_req)
      begin
        lat_rng    = xorshift(lat_rng);
        inst_wait  = int'(lat_rng % 32'd3);
        fetch_addr = inst_addr;
        inst_busy  = 1'b1;
      end
      if (inst_busy)
      begin
        if (inst_wait == 0)
        begin
          inst_resp <= 1'b1;
          inst_data <= prog_mem[fetch_addr[6:1]];
          inst_busy = 1'b0;
        end
        else
          inst_wait--;
      end
    end
  end

  // data memory, answers one cycle after the request.
  always @(posedge clk)
  begin
    mem_resp <= 1'b0;
    if (rst_i)
    begin
      for (int w = 0; w < 1024; w++)
        data_mem[w] <= init_mem[w];
    end
    else if (mem_req)
    begin
      mem_resp <= 1'b1;
      if (mem_write)
        data_mem[mem_addr[11:2]] <= mem_wdata;
      else
        mem_rdata <= data_mem[mem_addr[11:2]];
    end
  end

  initial
  begin
    load_images();
    repeat (10) @(posedge clk);
    rst_i <= 1'b0;
    wait (check_done);
    total_errors = check_errors + DUT.u_checker.fail_count;
    $display("closing: %0d compare errors, %0d assertion errors",
             check_errors, DUT.u_checker.fail_count);
    if (total_errors == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

  // watchdog, twelve cycles per model instruction plus margin.
  initial
  begin
    wait (model_ready);
    #(model_insts * 12 * 4 + 200);
    $display("watchdog: core did not finish %0d instructions in time", model_insts);
    $display("Checks failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: w0rm_lite.f
hdl/w0rm_lite_pkg.sv
hdl/w0rm_lite_control.sv
hdl/w0rm_lite_pc.sv
hdl/w0rm_lite_regfile.sv
hdl/w0rm_lite_execute.sv
hdl/w0rm_lite_top.sv
sim/w0rm_lite_checker.sv
sim/w0rm_lite_monitor.sv
sim/w0rm_lite_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module w0rm_lite_tb -Mdir obj_dir -f w0rm_lite.f

# the log decides the result, so the exit code of the run is not used
./obj_dir/Vw0rm_lite_tb +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "^All checks passed$" sim.log; then
  exit 0
fi
exit 1
